// File: s16_main.f
hdl/s16_main_pkg.sv
hdl/s16_addr_decode.sv
hdl/s16_cab_io.sv
hdl/s16_ppi.sv
hdl/s16_irq_gen.sv
hdl/s16_bus_ctrl.sv
hdl/s16_main.sv
verif/s16_main_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = s16_main_tb
RTL_TOP  = s16_main
FILELIST = s16_main.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) hdl/s16_main_pkg.sv \
		hdl/s16_addr_decode.sv hdl/s16_cab_io.sv hdl/s16_ppi.sv \
		hdl/s16_irq_gen.sv hdl/s16_bus_ctrl.sv hdl/s16_main.sv

clean:
	rm -rf obj_dir $(LOG)

// File: verif/s16_main_tb.sv
`timescale 1ns/1ps
`default_nettype none

/* System 16A main board glue testbench
   acts as the 68000 bus master, models ROM, RAM and video memories,
   and runs directed tests over map, wait states, cabinet, PPI and IRQ */

module s16_main_tb;
    localparam int max_cycles = 4000;   // about 70 bus cycles, under 30 clocks each

    logic clk = 1'b0;
    logic rst, as_n, uds_n, lds_n, rnw, rom_ok, ram_ok, vint, snd_ack;
    logic service, dip_test;
    logic [23:1] addr;
    logic [2:0]  fc;
    logic [15:0] cpu_dout, joyana1, joyana2;
    logic [7:0]  joystick1, joystick2, joystick3, joystick4;
    logic [7:0]  dipsw_a, dipsw_b, game_id;
    logic [3:0]  start_button;
    logic [1:0]  coin_input;
    wire  [15:0] cpu_din, rom_data, ram_data, char_dout, pal_dout, obj_dout;
    wire  [18:1] rom_addr;
    wire  [12:1] cpu_addr;
    wire  [2:0]  ipl_n;
    wire  [7:0]  snd_latch;
    wire  dtack_n, berr_n, rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs;
    wire  uds_w_n, lds_w_n, flip, colscr_en, rowscr_en, snd_irqn;

    int errors = 0;
    int cycles = 0;
    int rom_delay = 0;
    int wait_cnt = 0;
    int ok_edges = 0;     // consecutive rom_ok edges seen inside a rom cycle
    int last_resp;        // 0 dtack, 1 bus error, 2 no answer
    int ok_at_ack;
    logic [5:0] last_sel; // rom, ram, vram, char, pal, obj
    logic [1:0] lanes_n = 2'b00;  // uds_n, lds_n for the next cycles
    logic [1:0] last_wstb;        // uds_w_n, lds_w_n at the response

    function automatic logic [15:0] rom_word(input logic [18:1] ra);
        rom_word = {ra[8:1], ra[16:9]} ^ {ra[18:17], 14'h2b5};
    endfunction

    function automatic logic [15:0] vid_word(input logic [3:0] tag, input logic [12:1] ca);
        vid_word = {tag, ca ^ 12'h5a3};
    endfunction

    function automatic logic [7:0] joy_std(input logic [7:0] j);
        joy_std = {j[1:0], j[3:2], j[7], j[5:4], j[6]};
    endfunction

    function automatic logic [7:0] joy_pass(input logic [7:0] j);
        joy_pass = {j[7:4], j[1:0], j[3:2]};
    endfunction

    assign rom_data  = rom_word(rom_addr);
    assign ram_data  = ~{4'h9, cpu_addr};
    assign char_dout = vid_word(4'h1, cpu_addr);
    assign pal_dout  = vid_word(4'h2, cpu_addr);
    assign obj_dout  = vid_word(4'h3, cpu_addr);

    s16_main u_s16_main (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // rom ready goes high rom_delay edges into a rom cycle
    task automatic rom_model();
        forever begin
            @(posedge clk);
            if (!rom_cs || !rom_ok) ok_edges = 0;
            else ok_edges++;
            wait_cnt = rom_cs ? wait_cnt + 1 : 0;
            #1;
            rom_ok = wait_cnt >= rom_delay;
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one AS/DTACK cycle, entered and left 1 ns after a rising edge
    task automatic bus_cycle(input logic [23:0] a, input logic rd, input logic [15:0] wd,
                             output logic [15:0] rdata);
        int i;
        addr = a[23:1];
        rnw = rd;
        cpu_dout = wd;
        fc = 3'd5;
        uds_n = lanes_n[1];
        lds_n = lanes_n[0];
        as_n = 1'b0;
        last_resp = 2;
        for (i = 0; i < 20 && last_resp == 2; i++) begin
            @(negedge clk);
            if (!dtack_n) last_resp = 0;
            else if (!berr_n) last_resp = 1;
        end
        if (last_resp == 2) begin
            errors++;
            $display("no DTACK or bus error within 20 cycles at address %h", a);
        end
        rdata = cpu_din;
        ok_at_ack = ok_edges;
        last_sel = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs};
        last_wstb = {uds_w_n, lds_w_n};
        @(posedge clk);
        #1;
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic bus_read(input logic [23:0] a, output logic [15:0] d);
        bus_cycle(a, 1'b1, 16'h0000, d);
        check("read strobes", last_wstb, 2'b11);
    endtask

    task automatic bus_write(input logic [23:0] a, input logic [15:0] d);
        logic [15:0] unused;
        bus_cycle(a, 1'b0, d, unused);
        check("write dtack", last_resp, 0);
        check("write strobes", last_wstb, lanes_n); // follow the driven byte lanes
    endtask

    task automatic map_read(input logic [23:0] a, input logic [15:0] exp,
                            input logic [5:0] sel);
        logic [15:0] d;
        bus_read(a, d);
        check("dtack", last_resp, 0);
        check("cpu_din", d, exp);
        check("chip selects", last_sel, sel);
    endtask

    task automatic io_read(input logic [1:0] blk, input logic [1:0] port, input logic [7:0] exp);
        logic [15:0] d;
        bus_read(24'hc40000 | (24'(blk) << 12) | (24'(port) << 1), d);
        check("io dtack", last_resp, 0);
        check("io data", d, {8'hff, exp});
    endtask

    task automatic report(input string name, input int mark);
        $display("test %s finished with %0d errors", name, errors - mark);
    endtask

    task automatic reset_values();
        int mark;
        mark = errors;
        check("selects", {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs}, 0);
        check("dtack_n", dtack_n, 1);
        check("berr_n", berr_n, 1);
        check("ipl_n", ipl_n, 7);
        check("snd_irqn", snd_irqn, 1);
        check("flip", flip, 1);
        check("colscr_en", colscr_en, 0);
        check("rowscr_en", rowscr_en, 0);
        check("cpu_din", cpu_din, 16'hffff);
        report("reset", mark);
    endtask

    task automatic memory_map();
        int mark;
        logic [15:0] d;
        mark = errors;
        rom_delay = 0;
        map_read(24'h010abc, rom_word({1'b0, 17'h010abc >> 1}), 6'b100000);
        map_read(24'hc70ffe, ~{4'h9, 12'h7ff}, 6'b010000);
        map_read(24'h400246, ~{4'h9, 12'h123}, 6'b001000);
        map_read(24'h410124, vid_word(4'h1, 12'h092), 6'b000100);
        map_read(24'h840a42, vid_word(4'h2, 12'h521), 6'b000010);
        map_read(24'h440e08, vid_word(4'h3, 12'h704), 6'b000001);
        map_read(24'hc60000, 16'hffff, 6'b000000);
        bus_read(24'h600000, d);
        check("unmapped response", last_resp, 1);
        report("memory map", mark);
    endtask

    task automatic rom_wait_states();
        int mark;
        int delays[3] = '{0, 3, 7};
        logic [15:0] d;
        mark = errors;
        foreach (delays[k]) begin
            rom_delay = delays[k];
            bus_read(24'h03f2a6, d);
            check("rom dtack", last_resp, 0);
            check("rom data", d, rom_word(18'h03f2a6 >> 1));
            if (ok_at_ack < 3) begin
                errors++;
                $display("DTACK came %0d edges after rom_ok, delay %0d", ok_at_ack, delays[k]);
            end
        end
        rom_delay = 0;
        report("wait states", mark);
    endtask

    task automatic cabinet_inputs();
        int mark;
        logic [7:0] p0;
        mark = errors;
        bus_write(24'hc40002, 16'h0000);     // analog select low
        for (int g = 0; g < 3; g++) begin
            game_id = 8'(g);
            p0 = {2'b11, start_button[1:0], service, dip_test, coin_input};
            if (g == 1) p0[7:6] = {joystick2[4], joystick1[4]};
            if (g == 2) p0[7:6] = start_button[3:2];
            io_read(2'd1, 2'd0, p0);
            if (g == 1) begin
                io_read(2'd1, 2'd1, joyana1[7:0]);
                io_read(2'd1, 2'd3, joyana2[7:0]);
                bus_write(24'hc40002, 16'h0004);
                io_read(2'd1, 2'd1, 8'd0 - joyana1[15:8]);
                io_read(2'd1, 2'd3, 8'd0 - joyana2[15:8]);
                bus_write(24'hc40002, 16'h0000);
            end else if (g == 2) begin
                io_read(2'd1, 2'd1, joy_pass(joystick1));
                io_read(2'd1, 2'd1, joy_pass(joystick2));
                io_read(2'd1, 2'd1, joy_pass(joystick3));
                io_read(2'd1, 2'd1, joy_pass(joystick4));
                io_read(2'd1, 2'd1, joy_pass(joystick1)); // wraps, next is player 2
                io_read(2'd1, 2'd0, p0);
                io_read(2'd1, 2'd1, joy_pass(joystick1)); // counter restarted
                io_read(2'd1, 2'd3, joy_std(joystick2));
            end else begin
                io_read(2'd1, 2'd1, joy_std(joystick1));
                io_read(2'd1, 2'd3, joy_std(joystick2));
            end
            io_read(2'd1, 2'd2, 8'hff);
            io_read(2'd2, 2'd0, dipsw_a);
            io_read(2'd2, 2'd1, dipsw_b);
        end
        report("cabinet inputs", mark);
    endtask

    task automatic ppi_ports();
        int mark;
        mark = errors;
        lanes_n = 2'b10;                     // ppi sits on the low byte
        snd_ack = 1'b1;
        bus_write(24'hc40000, 16'h005c);
        bus_write(24'hc40002, 16'h007b);
        bus_write(24'hc40004, 16'h0002);
        check("snd_latch", snd_latch, 8'h5c);
        check("flip", flip, 0);
        check("snd_irqn", snd_irqn, 0);
        check("colscr_en", colscr_en, 1);
        check("rowscr_en", rowscr_en, 0);
        io_read(2'd0, 2'd0, 8'h5c);
        io_read(2'd0, 2'd1, 8'h7b);
        io_read(2'd0, 2'd2, 8'h42);          // bit 6 from snd_ack
        snd_ack = 1'b0;
        io_read(2'd0, 2'd2, 8'h02);
        bus_write(24'hc40004, 16'h0004);
        check("colscr_en", colscr_en, 0);
        check("rowscr_en", rowscr_en, 1);
        lanes_n = 2'b00;
        report("ppi", mark);
    endtask

    task automatic vblank_irq();
        int mark;
        mark = errors;
        vint = 1'b1;
        @(posedge clk);
        #1;
        check("ipl_n after vint", ipl_n, 3);
        map_read(24'h410124, vid_word(4'h1, 12'h092), 6'b000100);
        check("ipl_n held", ipl_n, 3);
        vint = 1'b0;
        fc = 3'd7;                           // acknowledge cycle, autovectored
        uds_n = 1'b0;
        lds_n = 1'b0;
        as_n = 1'b0;
        @(posedge clk);
        #1;
        check("ipl_n after ack", ipl_n, 7);
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        fc = 3'd5;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        report("interrupt", mark);
    endtask

    initial begin
        void'($urandom(32'h90a27d0a));
        rst = 1'b1;
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw = 1'b1;
        fc = 3'd5;
        addr = '0;
        cpu_dout = '0;
        rom_ok = 1'b1;
        ram_ok = 1'b1;
        vint = 1'b0;
        snd_ack = 1'b0;
        joystick1 = 8'($urandom);
        joystick2 = 8'($urandom);
        joystick3 = 8'($urandom);
        joystick4 = 8'($urandom);
        joyana1 = 16'($urandom);
        joyana2 = 16'($urandom);
        dipsw_a = 8'($urandom);
        dipsw_b = 8'($urandom);
        start_button = 4'($urandom);
        coin_input = 2'($urandom);
        service = 1'($urandom);
        dip_test = 1'($urandom);
        game_id = s16_main_pkg::game_std;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            rom_model();
        join_none
        reset_values();
        memory_map();
        rom_wait_states();
        cabinet_inputs();
        ppi_ports();
        vblank_irq();
        $display("%0d cycles run, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/s16_main.sv
`timescale 1ns/1ps
`default_nettype none

/* System 16A main board glue
   ties the memory map decoder, cabinet inputs, PPI, VBLANK interrupt
   and bus controller to the 68000-style bus and memory pins */

module s16_main (
    input  wire        clk,
    input  wire        rst,
    // cpu bus
    input  wire [23:1] addr,
    input  wire        as_n,
    input  wire        uds_n,
    input  wire        lds_n,
    input  wire        rnw,
    input  wire [2:0]  fc,
    input  wire [15:0] cpu_dout,
    output wire [15:0] cpu_din,
    output wire        dtack_n,
    output wire        berr_n,
    output wire [2:0]  ipl_n,
    // rom
    output wire        rom_cs,
    output wire [18:1] rom_addr,
    input  wire [15:0] rom_data,
    input  wire        rom_ok,
    // work ram and vram share one port
    output wire        ram_cs,
    output wire        vram_cs,
    input  wire [15:0] ram_data,
    input  wire        ram_ok,
    // video
    output wire        char_cs,
    output wire        pal_cs,
    output wire        objram_cs,
    input  wire [15:0] char_dout,
    input  wire [15:0] pal_dout,
    input  wire [15:0] obj_dout,
    output wire [12:1] cpu_addr,
    output wire        uds_w_n,
    output wire        lds_w_n,
    output wire        flip,
    output wire        colscr_en,
    output wire        rowscr_en,
    input  wire        vint,
    // sound
    output wire [7:0]  snd_latch,
    output wire        snd_irqn,
    input  wire        snd_ack,
    // cabinet
    input  wire [7:0]  joystick1,
    input  wire [7:0]  joystick2,
    input  wire [7:0]  joystick3,
    input  wire [7:0]  joystick4,
    input  wire [15:0] joyana1,
    input  wire [15:0] joyana2,
    input  wire [3:0]  start_button,
    input  wire [1:0]  coin_input,
    input  wire        service,
    input  wire        dip_test,
    input  wire [7:0]  dipsw_a,
    input  wire [7:0]  dipsw_b,
    input  wire [7:0]  game_id
);
    wire [3:0] region_q;
    wire       io_cs;
    wire [7:0] cab_dout;
    wire [7:0] ppi_dout;
    wire [7:0] ppi_portb;
    wire [7:0] ppi_portc;
    wire       is_ppi = addr[13:12] == s16_main_pkg::io_ppi;

    assign uds_w_n   = rnw | uds_n;
    assign lds_w_n   = rnw | lds_n;
    assign cpu_addr  = addr[12:1];
    assign rom_addr  = {1'b0, addr[17:1]};   // 256kB only
    assign flip      = ppi_portb[7];
    assign snd_irqn  = ppi_portc[7];
    assign colscr_en = ~ppi_portc[2];
    assign rowscr_en = ~ppi_portc[1];

    s16_addr_decode u_decode (
        .clk(clk), .rst(rst), .addr(addr), .as_n(as_n), .uds_n(uds_n), .lds_n(lds_n),
        .fc(fc), .region_q(region_q), .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs),
        .char_cs(char_cs), .pal_cs(pal_cs), .objram_cs(objram_cs), .io_cs(io_cs),
        .berr_n(berr_n)
    );

    s16_cab_io u_cab_io (
        .clk(clk), .rst(rst), .io_cs(io_cs), .addr_io({addr[13:12], addr[2:1]}),
        .game_id(game_id), .joystick1(joystick1), .joystick2(joystick2),
        .joystick3(joystick3), .joystick4(joystick4), .joyana1(joyana1), .joyana2(joyana2),
        .start_button(start_button), .coin_input(coin_input), .service(service),
        .dip_test(dip_test), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .ana_sel(ppi_portb[2]), .cab_dout(cab_dout)
    );

    s16_ppi u_ppi (
        .clk(clk), .rst(rst), .sel(io_cs & is_ppi), .reg_addr(addr[2:1]), .wr(~lds_w_n),
        .din(cpu_dout[7:0]), .portc_in6(snd_ack), .dout(ppi_dout), .porta(snd_latch),
        .portb(ppi_portb), .portc(ppi_portc)
    );

    s16_irq_gen u_irq (
        .clk(clk), .rst(rst), .vint(vint), .as_n(as_n), .fc(fc), .ipl_n(ipl_n)
    );

    s16_bus_ctrl u_bus_ctrl (
        .clk(clk), .rst(rst), .as_n(as_n), .region_q(region_q), .is_ppi(is_ppi),
        .rom_ok(rom_ok), .ram_ok(ram_ok), .rom_data(rom_data), .ram_data(ram_data),
        .char_dout(char_dout), .pal_dout(pal_dout), .obj_dout(obj_dout),
        .cab_dout(cab_dout), .ppi_dout(ppi_dout), .cpu_din(cpu_din), .dtack_n(dtack_n)
    );

endmodule

`default_nettype wire

// File: hdl/s16_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

/* read data mux and DTACK generation
   registers the data word picked by the decoded region and holds DTACK
   off until the data path has settled, waiting on ROM and RAM ready */

module s16_bus_ctrl (
    input  wire        clk,
    input  wire        rst,
    input  wire        as_n,
    input  wire [3:0]  region_q,
    input  wire        is_ppi,
    input  wire        rom_ok,
    input  wire        ram_ok,
    input  wire [15:0] rom_data,
    input  wire [15:0] ram_data,
    input  wire [15:0] char_dout,
    input  wire [15:0] pal_dout,
    input  wire [15:0] obj_dout,
    input  wire [7:0]  cab_dout,
    input  wire [7:0]  ppi_dout,
    output logic [15:0] cpu_din,
    output logic       dtack_n
);
    logic [15:0] rd_mux;
    logic [1:0]  dly_cnt;    // consecutive ready edges
    logic        active;
    logic        ready;

    assign active = !as_n && region_q != s16_main_pkg::reg_none;

    always_comb begin
        case (region_q)
            s16_main_pkg::reg_rom:  ready = rom_ok;
            s16_main_pkg::reg_ram,
            s16_main_pkg::reg_vram: ready = ram_ok;
            default:                ready = 1'b1;
        endcase
    end

    always_comb begin
        case (region_q)
            s16_main_pkg::reg_rom:  rd_mux = rom_data;
            s16_main_pkg::reg_ram,
            s16_main_pkg::reg_vram: rd_mux = ram_data;
            s16_main_pkg::reg_char: rd_mux = char_dout;
            s16_main_pkg::reg_pal:  rd_mux = pal_dout;
            s16_main_pkg::reg_obj:  rd_mux = obj_dout;
            s16_main_pkg::reg_io:
                rd_mux = {s16_main_pkg::idle_data[15:8], is_ppi ? ppi_dout : cab_dout};
            default:                rd_mux = s16_main_pkg::idle_data;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= s16_main_pkg::idle_data;
        end else begin
            cpu_din <= rd_mux;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dly_cnt <= 2'd0;
            dtack_n <= 1'b1;
        end else if (!active) begin
            dly_cnt <= 2'd0;
            dtack_n <= 1'b1;
        end else if (dtack_n) begin
            if (!ready) begin
                dly_cnt <= 2'd0;      // memory still busy, start over
            end else if (dly_cnt == 2'd2) begin
                dtack_n <= 1'b0;
            end else begin
                dly_cnt <= dly_cnt + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/s16_irq_gen.sv
`timescale 1ns/1ps
`default_nettype none

/* VBLANK interrupt
   a rising vint raises a level 4 request held until the CPU runs
   an interrupt acknowledge cycle */

module s16_irq_gen (
    input  wire        clk,
    input  wire        rst,
    input  wire        vint,
    input  wire        as_n,
    input  wire [2:0]  fc,
    output logic [2:0] ipl_n
);
    logic last_vint;
    logic inta;

    assign inta = !as_n && fc == 3'd7;   // cpu space cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_vint <= 1'b0;
            ipl_n     <= 3'd7;
        end else begin
            last_vint <= vint;
            if (inta) begin
                ipl_n <= 3'd7;
            end else if (vint && !last_vint) begin
                ipl_n <= 3'd3;       // only the top bit is driven low
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/s16_ppi.sv
`timescale 1ns/1ps
`default_nettype none

/* 8255-style parallel interface, mode 0 only
   three output ports written at addresses 0 to 2, with port C bit 6
   read back from the sound CPU acknowledge line */

module s16_ppi (
    input  wire        clk,
    input  wire        rst,
    input  wire        sel,
    input  wire [1:0]  reg_addr,
    input  wire        wr,
    input  wire [7:0]  din,
    input  wire        portc_in6,
    output logic [7:0] dout,
    output logic [7:0] porta,
    output logic [7:0] portb,
    output logic [7:0] portc
);
    logic       sel_q;    // sel seen on the previous edge
    logic       wr_en;
    logic [7:0] rd_mux;

    // lands one edge after sel rises, data is stable by then
    assign wr_en = sel && sel_q && wr;

    always_comb begin
        case (reg_addr)
            2'd0: rd_mux = porta;
            2'd1: rd_mux = portb;
            2'd2: rd_mux = {portc[7], portc_in6, portc[5:0]};
            default: rd_mux = 8'hff;   // control word not readable
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_q <= 1'b0;
            porta <= s16_main_pkg::ppi_reset_val;
            portb <= s16_main_pkg::ppi_reset_val;
            portc <= s16_main_pkg::ppi_reset_val;
        end else begin
            sel_q <= sel;
            if (wr_en) begin
                case (reg_addr)
                    2'd0: porta <= din;
                    2'd1: portb <= din;
                    2'd2: portc <= din;
                    default: ;          // mode word dropped, ports stay outputs
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout <= s16_main_pkg::ppi_reset_val;
        end else begin
            dout <= sel ? rd_mux : 8'hff;
        end
    end

endmodule

`default_nettype wire

// File: hdl/s16_cab_io.sv
`timescale 1ns/1ps
`default_nettype none

/* cabinet input multiplexer
   returns buttons, joysticks, analog sticks and dip switches per game.
   Passing Shot rotates four joysticks through port 1 */

module s16_cab_io (
    input  wire        clk,
    input  wire        rst,
    input  wire        io_cs,
    input  wire [3:0]  addr_io,      // {addr[13:12], addr[2:1]}
    input  wire [7:0]  game_id,
    input  wire [7:0]  joystick1,
    input  wire [7:0]  joystick2,
    input  wire [7:0]  joystick3,
    input  wire [7:0]  joystick4,
    input  wire [15:0] joyana1,
    input  wire [15:0] joyana2,
    input  wire [3:0]  start_button,
    input  wire [1:0]  coin_input,
    input  wire        service,
    input  wire        dip_test,
    input  wire [7:0]  dipsw_a,
    input  wire [7:0]  dipsw_b,
    input  wire        ana_sel,      // ppi port b bit 2
    output logic [7:0] cab_dout
);
    logic [1:0] port_cnt;   // passing shot player select
    logic       last_iocs;
    logic       new_cyc;
    logic [7:0] port0;
    logic [7:0] rd_mux;

    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    function automatic logic [7:0] pass_joy(input logic [7:0] joy);
        pass_joy = {joy[7:4], joy[1:0], joy[3:2]};
    endfunction

    // negated high byte when the ppi asks for the other axis
    function automatic logic [7:0] sdi_joy(input logic [15:0] ana, input logic hi);
        sdi_joy = hi ? (~ana[15:8] + 8'd1) : ana[7:0];
    endfunction

    assign new_cyc = io_cs && !last_iocs;

    always_comb begin
        port0 = {2'b11, start_button[1:0], service, dip_test, coin_input};
        if (game_id == s16_main_pkg::game_sdi) begin
            port0[7:6] = {joystick2[4], joystick1[4]};
        end else if (game_id == s16_main_pkg::game_passsht) begin
            port0[7:6] = start_button[3:2];
        end
    end

    always_comb begin
        rd_mux = 8'hff;
        case (addr_io[3:2])
            s16_main_pkg::io_cab: begin
                case (addr_io[1:0])
                    2'd0: rd_mux = port0;
                    2'd1: begin
                        if (game_id == s16_main_pkg::game_sdi) begin
                            rd_mux = sdi_joy(joyana1, ana_sel);
                        end else if (game_id == s16_main_pkg::game_passsht) begin
                            case (port_cnt)
                                2'd0: rd_mux = pass_joy(joystick1);
                                2'd1: rd_mux = pass_joy(joystick2);
                                2'd2: rd_mux = pass_joy(joystick3);
                                default: rd_mux = pass_joy(joystick4);
                            endcase
                        end else begin
                            rd_mux = sort_joy(joystick1);
                        end
                    end
                    2'd3: begin
                        if (game_id == s16_main_pkg::game_sdi) begin
                            rd_mux = sdi_joy(joyana2, ana_sel);
                        end else begin
                            rd_mux = sort_joy(joystick2);
                        end
                    end
                    default: rd_mux = 8'hff;
                endcase
            end
            s16_main_pkg::io_dip: rd_mux = addr_io[0] ? dipsw_b : dipsw_a;
            default: rd_mux = 8'hff;
        endcase
    end

    // data is captured once per access so the rotation cannot move under it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout  <= 8'hff;
            port_cnt  <= 2'd0;
            last_iocs <= 1'b0;
        end else begin
            last_iocs <= io_cs;
            if (!io_cs) begin
                cab_dout <= 8'hff;
            end else if (new_cyc) begin
                cab_dout <= rd_mux;
                if (addr_io == {s16_main_pkg::io_cab, 2'd0}) begin
                    port_cnt <= 2'd0;
                end else if (addr_io == {s16_main_pkg::io_cab, 2'd1} &&
                             game_id == s16_main_pkg::game_passsht) begin
                    port_cnt <= port_cnt + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/s16_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

/* System 16A memory map decoder
   registers one region code and the matching one-hot chip selects
   while AS is low, and a bus error for strobed unmapped cycles */

module s16_addr_decode (
    input  wire        clk,
    input  wire        rst,
    input  wire [23:1] addr,
    input  wire        as_n,
    input  wire        uds_n,
    input  wire        lds_n,
    input  wire [2:0]  fc,
    output logic [3:0] region_q,
    output logic       rom_cs,
    output logic       ram_cs,
    output logic       vram_cs,
    output logic       char_cs,
    output logic       pal_cs,
    output logic       objram_cs,
    output logic       io_cs,
    output logic       berr_n
);
    logic [3:0] region_d;
    logic       strobe;
    logic       iack;     // interrupt acknowledge, never decoded
    logic       cyc_q;    // region_q holds a real decode

    assign strobe = ~uds_n | ~lds_n;
    assign iack   = fc == 3'd7;

    always_comb begin
        region_d = s16_main_pkg::reg_none;
        if (!as_n && !iack) begin
            case (addr[23:16])
                8'h00, 8'h01, 8'h02, 8'h03: region_d = s16_main_pkg::reg_rom;
                8'h40: region_d = strobe ? s16_main_pkg::reg_vram : s16_main_pkg::reg_none;
                8'h41: region_d = s16_main_pkg::reg_char;
                8'h44: region_d = s16_main_pkg::reg_obj;
                8'h84: region_d = s16_main_pkg::reg_pal;
                8'hc4: region_d = s16_main_pkg::reg_io;
                8'hc6: region_d = s16_main_pkg::reg_wdog;
                8'hc7: region_d = strobe ? s16_main_pkg::reg_ram : s16_main_pkg::reg_none;
                default: region_d = s16_main_pkg::reg_none;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            region_q  <= s16_main_pkg::reg_none;
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            cyc_q     <= 1'b0;
            berr_n    <= 1'b1;
        end else begin
            region_q  <= region_d;
            rom_cs    <= region_d == s16_main_pkg::reg_rom;
            ram_cs    <= region_d == s16_main_pkg::reg_ram;
            vram_cs   <= region_d == s16_main_pkg::reg_vram;
            char_cs   <= region_d == s16_main_pkg::reg_char;
            pal_cs    <= region_d == s16_main_pkg::reg_pal;
            objram_cs <= region_d == s16_main_pkg::reg_obj;
            io_cs     <= region_d == s16_main_pkg::reg_io;
            cyc_q     <= !as_n && !iack;
            // one edge behind the decode, released as soon as AS goes high
            berr_n    <= !(!as_n && cyc_q && strobe && region_q == s16_main_pkg::reg_none);
        end
    end

endmodule

`default_nettype wire

// File: hdl/s16_main_pkg.sv
`default_nettype none

/* System 16A main board shared definitions
   game ids for the cabinet input mux, region codes passed from the
   address decoder to the bus controller, I/O sub-block selects and
   reset values for the PPI and idle bus reads */

package s16_main_pkg;

    // game ids, compared against the game_id pins
    localparam logic [7:0] game_std     = 8'd0;
    localparam logic [7:0] game_sdi     = 8'd1;
    localparam logic [7:0] game_passsht = 8'd2;

    // decoded regions, one per registered chip select
    localparam logic [3:0] reg_none = 4'd0;
    localparam logic [3:0] reg_rom  = 4'd1; // 00-03
    localparam logic [3:0] reg_ram  = 4'd2; // c7
    localparam logic [3:0] reg_vram = 4'd3; // 40
    localparam logic [3:0] reg_char = 4'd4; // 41
    localparam logic [3:0] reg_pal  = 4'd5; // 84
    localparam logic [3:0] reg_obj  = 4'd6; // 44
    localparam logic [3:0] reg_io   = 4'd7; // c4
    localparam logic [3:0] reg_wdog = 4'd8; // c6, acknowledged only

    // address bits 13:12 inside the io region
    localparam logic [1:0] io_ppi = 2'd0;
    localparam logic [1:0] io_cab = 2'd1;
    localparam logic [1:0] io_dip = 2'd2;

    localparam logic [7:0]  ppi_reset_val = 8'hff;
    localparam logic [15:0] idle_data     = 16'hffff; // open bus

endpackage

`default_nettype wire
